/* source/core_trace_macros.svh */
// Core trace unit constants for widths, depths and register offsets
`ifndef CORE_TRACE_MACROS_SVH
`define CORE_TRACE_MACROS_SVH

// Machine word and record shape
`define CT_DATA_W      32
`define CT_REC_WORDS   5

// Default record buffer depth, a power of two
`define CT_FIFO_DEPTH  16

// Local data memory address bits
`define CT_DMEM_ADDR_W 10

// AXI4-Lite register map
`define CT_AXI_ADDR_W  6
`define CT_REG_CTRL    6'h00
`define CT_REG_STATUS  6'h04
`define CT_REG_DROP    6'h08
`define CT_REG_REC0    6'h10
`define CT_REG_REC1    6'h14
`define CT_REG_REC2    6'h18
`define CT_REG_REC3    6'h1C
`define CT_REG_REC4    6'h20

`endif

/* source/core_trace_pkg.sv */
// Core trace package with the shared vector types and state encodings
`include "core_trace_macros.svh"

package core_trace_pkg;

  typedef logic [`CT_DATA_W-1:0]      word_t;
  typedef logic [`CT_DATA_W-1:0]      pc_t;
  typedef logic [`CT_DMEM_ADDR_W-1:0] dmem_addr_t;
  typedef logic [4:0]                 reg_addr_t;
  typedef logic [15:0]                stamp_t;

  // Memory access seen at execute
  typedef enum logic [2:0] {
    ACC_NONE   = 3'd0,
    ACC_LLOAD  = 3'd1,
    ACC_LSTORE = 3'd2,
    ACC_RLOAD  = 3'd3,
    ACC_RSTORE = 3'd4
  } access_kind_e;

  // Stall reasons, lowest nonzero value wins
  typedef enum logic [3:0] {
    ST_NONE   = 4'd0,
    ST_IFETCH = 4'd1,
    ST_ISTORE = 4'd2,
    ST_LRAQ   = 4'd3,
    ST_FENCE  = 4'd4,
    ST_MULDIV = 4'd5,
    ST_LOADWB = 4'd6,
    ST_MEMREQ = 4'd7,
    ST_FLW    = 4'd8
  } stall_cause_e;

  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_RESP = 2'd1
  } axi_wr_state_e;

  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_DATA = 1'b1
  } axi_rd_state_e;

endpackage

/* source/trace_stage_align.sv */
// Trace stage alignment, carries execute-stage observations to writeback
`timescale 1ns/1ns

module trace_stage_align (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      stall_i,
  input  logic                      exe_v_i,
  input  core_trace_pkg::pc_t       exe_pc_i,
  input  core_trace_pkg::word_t     exe_instr_i,
  input  logic                      exe_branch_i,
  input  core_trace_pkg::word_t     btarget_i,
  input  logic                      lsu_v_i,
  input  logic                      lsu_w_i,
  input  core_trace_pkg::dmem_addr_t lsu_addr_i,
  input  core_trace_pkg::word_t     lsu_data_i,
  input  logic                      rreq_v_i,
  input  logic                      rreq_w_i,
  input  core_trace_pkg::word_t     rreq_addr_i,
  input  core_trace_pkg::word_t     rreq_data_i,
  input  core_trace_pkg::word_t     ld_data_i,
  output logic                      wb_bubble_o,
  output core_trace_pkg::pc_t       wb_pc_o,
  output core_trace_pkg::word_t     wb_instr_o,
  output logic                      wb_branch_o,
  output core_trace_pkg::access_kind_e wb_kind_o,
  output core_trace_pkg::word_t     wb_addr_o,
  output core_trace_pkg::word_t     wb_sdata_o,
  output core_trace_pkg::word_t     wb_ldata_o
);
  import core_trace_pkg::*;

  access_kind_e exe_kind;
  logic         exe_branch;
  word_t        exe_addr;
  word_t        exe_sdata;

  // Memory stage copy
  logic         mem_bubble_q;
  logic         mem_branch_q;
  access_kind_e mem_kind_q;
  pc_t          mem_pc_q;
  word_t        mem_instr_q;
  word_t        mem_addr_q;
  word_t        mem_sdata_q;

  assign exe_branch = exe_v_i & exe_branch_i;

  // Local before remote, load before store
  always_comb begin
    exe_kind = ACC_NONE;
    if (exe_v_i) begin
      if (lsu_v_i && !lsu_w_i)
        exe_kind = ACC_LLOAD;
      else if (lsu_v_i)
        exe_kind = ACC_LSTORE;
      else if (rreq_v_i && !rreq_w_i)
        exe_kind = ACC_RLOAD;
      else if (rreq_v_i)
        exe_kind = ACC_RSTORE;
    end
  end

  always_comb begin
    exe_sdata = '0;
    case (exe_kind)
      ACC_LLOAD, ACC_LSTORE: exe_addr = word_t'(lsu_addr_i);
      ACC_RLOAD, ACC_RSTORE: exe_addr = rreq_addr_i;
      default:               exe_addr = exe_branch ? btarget_i : '0;
    endcase
    if (exe_kind == ACC_LSTORE)
      exe_sdata = lsu_data_i;
    else if (exe_kind == ACC_RSTORE)
      exe_sdata = rreq_data_i;
  end

  // Stage control, both slots start as bubbles
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_bubble_q <= 1'b1;
      mem_branch_q <= 1'b0;
      mem_kind_q   <= ACC_NONE;
      wb_bubble_o  <= 1'b1;
      wb_branch_o  <= 1'b0;
      wb_kind_o    <= ACC_NONE;
    end else if (!stall_i) begin
      mem_bubble_q <= ~exe_v_i;
      mem_branch_q <= exe_branch;
      mem_kind_q   <= exe_kind;
      wb_bubble_o  <= mem_bubble_q;
      wb_branch_o  <= mem_branch_q;
      wb_kind_o    <= mem_kind_q;
    end
  end

  // Payload, load data is caught on the move into writeback
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      mem_pc_q    <= exe_pc_i;
      mem_instr_q <= exe_instr_i;
      mem_addr_q  <= exe_addr;
      mem_sdata_q <= exe_sdata;
      wb_pc_o     <= mem_pc_q;
      wb_instr_o  <= mem_instr_q;
      wb_addr_o   <= mem_addr_q;
      wb_sdata_o  <= mem_sdata_q;
      wb_ldata_o  <= ld_data_i;
    end
  end

endmodule

/* source/trace_record_pack.sv */
// Trace record packer, stamps, filters and registers one record per cycle
`timescale 1ns/1ns
`include "core_trace_macros.svh"

module trace_record_pack (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         wb_bubble_i,
  input  core_trace_pkg::pc_t          wb_pc_i,
  input  core_trace_pkg::word_t        wb_instr_i,
  input  logic                         wb_branch_i,
  input  core_trace_pkg::access_kind_e wb_kind_i,
  input  core_trace_pkg::word_t        wb_addr_i,
  input  core_trace_pkg::word_t        wb_sdata_i,
  input  core_trace_pkg::word_t        wb_ldata_i,
  input  logic                         rf_wen_i,
  input  core_trace_pkg::reg_addr_t    rf_waddr_i,
  input  core_trace_pkg::word_t        rf_wdata_i,
  input  logic                         stall_i,
  input  logic [7:0]                   stall_cause_i,
  input  logic                         enable_i,
  input  logic                         skip_bubbles_i,
  input  logic                         skip_stalls_i,
  output logic                         rec_v_o,
  output core_trace_pkg::word_t [`CT_REC_WORDS-1:0] rec_words_o
);
  import core_trace_pkg::*;

  stamp_t       stamp_q;
  stall_cause_e cause;
  word_t        rec_data;
  logic         take;

  // Free-running cycle stamp
  always_ff @(posedge clk_i) begin
    if (reset_i)
      stamp_q <= '0;
    else
      stamp_q <= stamp_q + 1'b1;
  end

  // Scan from the top so the lowest set bit ends up winning
  always_comb begin
    cause = ST_NONE;
    if (stall_i) begin
      for (int i = 7; i >= 0; i--) begin
        if (stall_cause_i[i])
          cause = stall_cause_e'(4'(i + 1));
      end
    end
  end

  always_comb begin
    case (wb_kind_i)
      ACC_LLOAD:              rec_data = wb_ldata_i;
      ACC_LSTORE, ACC_RSTORE: rec_data = wb_sdata_i;
      default:                rec_data = rf_wen_i ? rf_wdata_i : '0;
    endcase
  end

  assign take = enable_i
              & ~(skip_bubbles_i & wb_bubble_i)
              & ~(skip_stalls_i & stall_i);

  always_ff @(posedge clk_i) begin
    if (reset_i)
      rec_v_o <= 1'b0;
    else
      rec_v_o <= take;
  end

  // Address word was already chosen in the align stage
  always_ff @(posedge clk_i) begin
    if (take) begin
      rec_words_o[0] <= {stamp_q, cause, wb_kind_i, wb_branch_i, rf_wen_i,
                         wb_bubble_i, 1'b0, rf_waddr_i};
      rec_words_o[1] <= wb_pc_i;
      rec_words_o[2] <= wb_instr_i;
      rec_words_o[3] <= wb_addr_i;
      rec_words_o[4] <= rec_data;
    end
  end

endmodule

/* source/trace_fifo.sv */
// Trace record FIFO with fill count and a saturating overflow counter
`timescale 1ns/1ns
`include "core_trace_macros.svh"

module trace_fifo #(
  parameter int DEPTH = `CT_FIFO_DEPTH
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      wr_v_i,
  input  core_trace_pkg::word_t [`CT_REC_WORDS-1:0] wr_words_i,
  input  logic                                      pop_i,
  input  logic                                      clear_i,
  output core_trace_pkg::word_t [`CT_REC_WORDS-1:0] head_words_o,
  output logic [15:0]                               count_o,
  output logic                                      full_o,
  output logic                                      empty_o,
  output core_trace_pkg::word_t                     drop_count_o
);
  import core_trace_pkg::*;

  localparam int AW = $clog2(DEPTH);

  word_t [`CT_REC_WORDS-1:0] mem_q [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic          wr_ok;
  logic          rd_ok;

  assign full_o  = (count_o == 16'(DEPTH));
  assign empty_o = (count_o == '0);
  assign wr_ok   = wr_v_i & ~full_o;
  assign rd_ok   = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_o      <= '0;
      drop_count_o <= '0;
    end else begin
      if (wr_ok)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_ok)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      count_o <= count_o + 16'(wr_ok) - 16'(rd_ok);
      // Lost records, held at all ones once reached
      if (wr_v_i && full_o && drop_count_o != '1)
        drop_count_o <= drop_count_o + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_ok)
      mem_q[wr_ptr_q] <= wr_words_i;
  end

  assign head_words_o = mem_q[rd_ptr_q];

endmodule

/* source/trace_csr.sv */
// Trace control and status registers behind an AXI4-Lite slave port
`timescale 1ns/1ns
`include "core_trace_macros.svh"

module trace_csr (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      s_awvalid_i,
  input  logic [`CT_AXI_ADDR_W-1:0]                 s_awaddr_i,
  output logic                                      s_awready_o,
  input  logic                                      s_wvalid_i,
  input  core_trace_pkg::word_t                     s_wdata_i,
  input  logic [3:0]                                s_wstrb_i,
  output logic                                      s_wready_o,
  output logic                                      s_bvalid_o,
  output logic [1:0]                                s_bresp_o,
  input  logic                                      s_bready_i,
  input  logic                                      s_arvalid_i,
  input  logic [`CT_AXI_ADDR_W-1:0]                 s_araddr_i,
  output logic                                      s_arready_o,
  output logic                                      s_rvalid_o,
  output core_trace_pkg::word_t                     s_rdata_o,
  output logic [1:0]                                s_rresp_o,
  input  logic                                      s_rready_i,
  input  core_trace_pkg::word_t [`CT_REC_WORDS-1:0] head_words_i,
  input  logic [15:0]                               count_i,
  input  logic                                      full_i,
  input  logic                                      empty_i,
  input  core_trace_pkg::word_t                     drop_count_i,
  output logic                                      enable_o,
  output logic                                      skip_bubbles_o,
  output logic                                      skip_stalls_o,
  output logic                                      pop_o,
  output logic                                      clear_o
);
  import core_trace_pkg::*;

  axi_wr_state_e wr_state_q;
  axi_rd_state_e rd_state_q;
  logic [2:0]    ctrl_q;
  logic          clear_q;
  logic          wr_accept;
  logic          ar_accept;
  word_t         rd_mux;

  assign enable_o       = ctrl_q[0];
  assign skip_bubbles_o = ctrl_q[1];
  assign skip_stalls_o  = ctrl_q[2];
  assign clear_o        = clear_q;

  // Write channel, address and data taken together
  assign s_awready_o = (wr_state_q == WR_IDLE);
  assign s_wready_o  = (wr_state_q == WR_IDLE);
  assign s_bvalid_o  = (wr_state_q == WR_RESP);
  assign s_bresp_o   = 2'b00;
  assign wr_accept   = s_awvalid_i & s_wvalid_i & (wr_state_q == WR_IDLE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_q <= WR_IDLE;
      ctrl_q     <= '0;
      clear_q    <= 1'b0;
    end else begin
      clear_q <= 1'b0;
      case (wr_state_q)
        WR_IDLE: begin
          if (wr_accept) begin
            wr_state_q <= WR_RESP;
            // Only CTRL is writable, all its bits sit in byte 0
            if (s_awaddr_i == `CT_REG_CTRL && s_wstrb_i[0]) begin
              ctrl_q  <= s_wdata_i[2:0];
              clear_q <= s_wdata_i[3];
            end
          end
        end
        WR_RESP: begin
          if (s_bready_i)
            wr_state_q <= WR_IDLE;
        end
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  // Read channel
  assign s_arready_o = (rd_state_q == RD_IDLE);
  assign s_rvalid_o  = (rd_state_q == RD_DATA);
  assign s_rresp_o   = 2'b00;
  assign ar_accept   = s_arvalid_i & s_arready_o;

  // Reading the last record word retires the head
  assign pop_o = ar_accept & (s_araddr_i == `CT_REG_REC4);

  always_comb begin
    case (s_araddr_i)
      `CT_REG_CTRL:   rd_mux = word_t'(ctrl_q);
      `CT_REG_STATUS: rd_mux = word_t'({full_i, empty_i, count_i});
      `CT_REG_DROP:   rd_mux = drop_count_i;
      `CT_REG_REC0:   rd_mux = head_words_i[0];
      `CT_REG_REC1:   rd_mux = head_words_i[1];
      `CT_REG_REC2:   rd_mux = head_words_i[2];
      `CT_REG_REC3:   rd_mux = head_words_i[3];
      `CT_REG_REC4:   rd_mux = head_words_i[4];
      default:        rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      rd_state_q <= RD_IDLE;
    else if (ar_accept)
      rd_state_q <= RD_DATA;
    else if (s_rvalid_o && s_rready_i)
      rd_state_q <= RD_IDLE;
  end

  always_ff @(posedge clk_i) begin
    if (ar_accept)
      s_rdata_o <= rd_mux;
  end

endmodule

/* source/core_trace_top.sv */
// Core trace unit top, from pipeline observation to AXI4-Lite readout
`timescale 1ns/1ns
`include "core_trace_macros.svh"

module core_trace_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       exe_v_i,
  input  core_trace_pkg::pc_t        exe_pc_i,
  input  core_trace_pkg::word_t      exe_instr_i,
  input  logic                       exe_branch_i,
  input  core_trace_pkg::word_t      btarget_i,
  input  logic                       lsu_v_i,
  input  logic                       lsu_w_i,
  input  core_trace_pkg::dmem_addr_t lsu_addr_i,
  input  core_trace_pkg::word_t      lsu_data_i,
  input  logic                       rreq_v_i,
  input  logic                       rreq_w_i,
  input  core_trace_pkg::word_t      rreq_addr_i,
  input  core_trace_pkg::word_t      rreq_data_i,
  input  core_trace_pkg::word_t      ld_data_i,
  input  logic                       rf_wen_i,
  input  core_trace_pkg::reg_addr_t  rf_waddr_i,
  input  core_trace_pkg::word_t      rf_wdata_i,
  input  logic                       stall_i,
  input  logic [7:0]                 stall_cause_i,
  input  logic                       s_awvalid_i,
  input  logic [`CT_AXI_ADDR_W-1:0]  s_awaddr_i,
  output logic                       s_awready_o,
  input  logic                       s_wvalid_i,
  input  core_trace_pkg::word_t      s_wdata_i,
  input  logic [3:0]                 s_wstrb_i,
  output logic                       s_wready_o,
  output logic                       s_bvalid_o,
  output logic [1:0]                 s_bresp_o,
  input  logic                       s_bready_i,
  input  logic                       s_arvalid_i,
  input  logic [`CT_AXI_ADDR_W-1:0]  s_araddr_i,
  output logic                       s_arready_o,
  output logic                       s_rvalid_o,
  output core_trace_pkg::word_t      s_rdata_o,
  output logic [1:0]                 s_rresp_o,
  input  logic                       s_rready_i
);
  import core_trace_pkg::*;

  // Writeback-aligned observation
  logic         wb_bubble, wb_branch;
  pc_t          wb_pc;
  word_t        wb_instr, wb_addr, wb_sdata, wb_ldata;
  access_kind_e wb_kind;

  // Record path and control
  logic                      rec_v, enable, skip_bubbles, skip_stalls, pop, clear;
  word_t [`CT_REC_WORDS-1:0] rec_words, head_words;
  logic [15:0]               count;
  logic                      full, empty;
  word_t                     drop_count;

  trace_stage_align align0 (
    .clk_i, .reset_i, .stall_i, .exe_v_i, .exe_pc_i, .exe_instr_i, .exe_branch_i,
    .btarget_i, .lsu_v_i, .lsu_w_i, .lsu_addr_i, .lsu_data_i,
    .rreq_v_i, .rreq_w_i, .rreq_addr_i, .rreq_data_i, .ld_data_i,
    .wb_bubble_o(wb_bubble), .wb_pc_o(wb_pc), .wb_instr_o(wb_instr),
    .wb_branch_o(wb_branch), .wb_kind_o(wb_kind), .wb_addr_o(wb_addr),
    .wb_sdata_o(wb_sdata), .wb_ldata_o(wb_ldata)
  );

  trace_record_pack pack0 (
    .clk_i, .reset_i, .rf_wen_i, .rf_waddr_i, .rf_wdata_i, .stall_i, .stall_cause_i,
    .wb_bubble_i(wb_bubble), .wb_pc_i(wb_pc), .wb_instr_i(wb_instr),
    .wb_branch_i(wb_branch), .wb_kind_i(wb_kind), .wb_addr_i(wb_addr),
    .wb_sdata_i(wb_sdata), .wb_ldata_i(wb_ldata),
    .enable_i(enable), .skip_bubbles_i(skip_bubbles), .skip_stalls_i(skip_stalls),
    .rec_v_o(rec_v), .rec_words_o(rec_words)
  );

  trace_fifo #(.DEPTH(`CT_FIFO_DEPTH)) fifo0 (
    .clk_i, .reset_i, .wr_v_i(rec_v), .wr_words_i(rec_words), .pop_i(pop),
    .clear_i(clear), .head_words_o(head_words), .count_o(count), .full_o(full),
    .empty_o(empty), .drop_count_o(drop_count)
  );

  trace_csr csr0 (
    .clk_i, .reset_i, .s_awvalid_i, .s_awaddr_i, .s_awready_o,
    .s_wvalid_i, .s_wdata_i, .s_wstrb_i, .s_wready_o,
    .s_bvalid_o, .s_bresp_o, .s_bready_i,
    .s_arvalid_i, .s_araddr_i, .s_arready_o,
    .s_rvalid_o, .s_rdata_o, .s_rresp_o, .s_rready_i,
    .head_words_i(head_words), .count_i(count), .full_i(full), .empty_i(empty),
    .drop_count_i(drop_count), .enable_o(enable), .skip_bubbles_o(skip_bubbles),
    .skip_stalls_o(skip_stalls), .pop_o(pop), .clear_o(clear)
  );

endmodule

/* dv/core_trace_chk.sv */
// Trace unit checker with AXI response hold and FIFO occupancy assertions
`timescale 1ns/1ns
`include "core_trace_macros.svh"

module core_trace_chk #(
  parameter int DEPTH = `CT_FIFO_DEPTH
) (
  input logic        clk_i,
  input logic        reset_i,
  input logic        bvalid_i,
  input logic        bready_i,
  input logic        rvalid_i,
  input logic        rready_i,
  input logic [15:0] count_i,
  input logic        full_i,
  input logic        empty_i
);

  // Responses stay up until the master takes them
  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  a_count_max: assert property (@(posedge clk_i) disable iff (reset_i)
    count_i <= 16'(DEPTH))
    else $error("FIFO count above depth");

  a_full_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    !(full_i && empty_i))
    else $error("FIFO full and empty together");

endmodule

bind trace_csr core_trace_chk #(.DEPTH(`CT_FIFO_DEPTH)) csr_chk0 (
  .clk_i(clk_i), .reset_i(reset_i), .bvalid_i(s_bvalid_o), .bready_i(s_bready_i),
  .rvalid_i(s_rvalid_o), .rready_i(s_rready_i), .count_i(count_i),
  .full_i(full_i), .empty_i(empty_i)
);

// FIFO side only, the AXI inputs are tied off
bind trace_fifo core_trace_chk #(.DEPTH(`CT_FIFO_DEPTH)) fifo_chk0 (
  .clk_i(clk_i), .reset_i(reset_i), .bvalid_i(1'b0), .bready_i(1'b0),
  .rvalid_i(1'b0), .rready_i(1'b0), .count_i(count_o),
  .full_i(full_o), .empty_i(empty_o)
);

/* dv/core_trace_tb.sv */
// Core trace unit testbench with random core traffic and a cycle-level model
`timescale 1ns/1ns
`include "core_trace_macros.svh"

module core_trace_tb;
  import core_trace_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int TEST_CYCLES = 2000;
  localparam int DEPTH       = `CT_FIFO_DEPTH;

  typedef logic [`CT_REC_WORDS-1:0][`CT_DATA_W-1:0] rec_t;

  logic        clk_i = 1'b0;
  logic        reset_i;

  // Core observation stimulus
  logic        exe_v, exe_branch, lsu_v, lsu_w, rreq_v, rreq_w, rf_wen, stall;
  logic [31:0] exe_pc, exe_instr, btarget, lsu_data, rreq_addr, rreq_data;
  logic [31:0] ld_data, rf_wdata;
  logic [9:0]  lsu_addr;
  logic [4:0]  rf_waddr;
  logic [7:0]  stall_cause;

  // AXI4-Lite master side
  logic        awvalid, wvalid, bready, arvalid, rready;
  logic        awready, wready, bvalid, arready, rvalid;
  logic [5:0]  awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;

  // Model of memory and writeback stages
  logic        m_bub, m_br, w_bub, w_br;
  logic [2:0]  m_kind, w_kind;
  logic [31:0] m_pc, m_instr, m_addr, m_sdata;
  logic [31:0] w_pc, w_instr, w_addr, w_sdata, w_ldata;

  // Model of stamp, packed record, buffer and control
  logic [15:0] stamp;
  logic        pend_v;
  rec_t        pend_rec;
  rec_t        model_q[$];
  logic [31:0] model_drop;
  logic [2:0]  model_ctrl;
  logic        model_clr, model_pop;

  core_trace_top dut0 (
    .clk_i, .reset_i,
    .exe_v_i(exe_v), .exe_pc_i(exe_pc), .exe_instr_i(exe_instr),
    .exe_branch_i(exe_branch), .btarget_i(btarget),
    .lsu_v_i(lsu_v), .lsu_w_i(lsu_w), .lsu_addr_i(lsu_addr), .lsu_data_i(lsu_data),
    .rreq_v_i(rreq_v), .rreq_w_i(rreq_w), .rreq_addr_i(rreq_addr),
    .rreq_data_i(rreq_data), .ld_data_i(ld_data),
    .rf_wen_i(rf_wen), .rf_waddr_i(rf_waddr), .rf_wdata_i(rf_wdata),
    .stall_i(stall), .stall_cause_i(stall_cause),
    .s_awvalid_i(awvalid), .s_awaddr_i(awaddr), .s_awready_o(awready),
    .s_wvalid_i(wvalid), .s_wdata_i(wdata), .s_wstrb_i(wstrb), .s_wready_o(wready),
    .s_bvalid_o(bvalid), .s_bresp_o(bresp), .s_bready_i(bready),
    .s_arvalid_i(arvalid), .s_araddr_i(araddr), .s_arready_o(arready),
    .s_rvalid_o(rvalid), .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rready_i(rready)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TEST_CYCLES * CLK_PERIOD * 4);
    $display("Timeout: the test sequence did not complete in the allowed time");
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s, got 0x%08h expected 0x%08h",
               $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // First set bit gives the cause with bit 0 as ST_IFETCH
  function automatic logic [3:0] cause_code(input logic stalled, input logic [7:0] bits);
    logic [3:0] code;
    code = 4'd0;
    if (stalled) begin
      for (int i = 0; i < 8; i++) begin
        if (bits[i] && code == 4'd0)
          code = 4'(i + 1);
      end
    end
    return code;
  endfunction

  function automatic logic [31:0] expected_status();
    logic [15:0] cnt;
    cnt = 16'(model_q.size());
    return {14'd0, cnt == 16'(DEPTH), cnt == 16'd0, cnt};
  endfunction

  // One clock edge of the reference model with inputs as they were at the edge
  task automatic model_step();
    logic        pre_full;
    logic        pre_empty;
    logic        take;
    logic [2:0]  kind;
    logic [31:0] addr;
    logic [31:0] sdata;
    logic [31:0] data;
    kind = ACC_NONE;
    if (exe_v && lsu_v)
      kind = lsu_w ? ACC_LSTORE : ACC_LLOAD;
    else if (exe_v && rreq_v)
      kind = rreq_w ? ACC_RSTORE : ACC_RLOAD;
    if (kind == ACC_LLOAD || kind == ACC_LSTORE)
      addr = {22'd0, lsu_addr};
    else if (kind == ACC_RLOAD || kind == ACC_RSTORE)
      addr = rreq_addr;
    else if (exe_v && exe_branch)
      addr = btarget;
    else
      addr = 32'd0;
    sdata = 32'd0;
    if (kind == ACC_LSTORE)
      sdata = lsu_data;
    if (kind == ACC_RSTORE)
      sdata = rreq_data;
    if (reset_i) begin
      m_bub = 1'b1;
      m_br = 1'b0;
      m_kind = ACC_NONE;
      w_bub = 1'b1;
      w_br = 1'b0;
      w_kind = ACC_NONE;
      stamp = 16'd0;
      pend_v = 1'b0;
      model_q.delete();
      model_drop = 32'd0;
      model_ctrl = 3'd0;
      model_clr = 1'b0;
    end else begin
      pre_full = (model_q.size() == DEPTH);
      pre_empty = (model_q.size() == 0);
      if (model_clr) begin
        model_q.delete();
        model_drop = 32'd0;
        model_clr = 1'b0;
      end else begin
        if (model_pop && !pre_empty)
          void'(model_q.pop_front());
        if (pend_v && !pre_full)
          model_q.push_back(pend_rec);
        else if (pend_v && model_drop != 32'hFFFF_FFFF)
          model_drop = model_drop + 32'd1;
      end
      take = model_ctrl[0] && !(model_ctrl[1] && w_bub) && !(model_ctrl[2] && stall);
      if (take) begin
        if (w_kind == ACC_LLOAD)
          data = w_ldata;
        else if (w_kind == ACC_LSTORE || w_kind == ACC_RSTORE)
          data = w_sdata;
        else
          data = rf_wen ? rf_wdata : 32'd0;
        pend_rec[0] = {stamp, cause_code(stall, stall_cause), w_kind, w_br, rf_wen,
                       w_bub, 1'b0, rf_waddr};
        pend_rec[1] = w_pc;
        pend_rec[2] = w_instr;
        pend_rec[3] = w_addr;
        pend_rec[4] = data;
      end
      pend_v = take;
      stamp = stamp + 16'd1;
      if (!stall) begin
        w_bub = m_bub;
        w_br = m_br;
        w_kind = m_kind;
        m_bub = !exe_v;
        m_br = exe_v && exe_branch;
        m_kind = kind;
      end
    end
    // Payload moves in reset too
    if (!stall) begin
      w_pc = m_pc;
      w_instr = m_instr;
      w_addr = m_addr;
      w_sdata = m_sdata;
      w_ldata = ld_data;
      m_pc = exe_pc;
      m_instr = exe_instr;
      m_addr = addr;
      m_sdata = sdata;
    end
  endtask

  task automatic drive_core();
    exe_v = ($urandom % 4) != 0;
    exe_pc = $urandom & 32'hFFFF_FFFC;
    exe_instr = $urandom;
    exe_branch = ($urandom % 4) == 0;
    btarget = $urandom & 32'hFFFF_FFFC;
    lsu_v = ($urandom % 3) == 0;
    lsu_w = 1'($urandom % 2);
    lsu_addr = 10'($urandom);
    lsu_data = $urandom;
    rreq_v = ($urandom % 4) == 0;
    rreq_w = 1'($urandom % 2);
    rreq_addr = $urandom;
    rreq_data = $urandom;
    ld_data = $urandom;
    rf_wen = 1'($urandom % 2);
    rf_waddr = 5'($urandom);
    rf_wdata = $urandom;
    stall = ($urandom % 4) == 0;
    stall_cause = 8'($urandom);
  endtask

  task automatic tick();
    @(negedge clk_i);
    model_step();
    drive_core();
  endtask

  task automatic axi_write(input logic [5:0] addr, input logic [31:0] data);
    awvalid = 1'b1;
    awaddr = addr;
    wvalid = 1'b1;
    wdata = data;
    wstrb = 4'hF;
    while (!(awready && wready))
      tick();
    tick();
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b1;
    if (addr == `CT_REG_CTRL) begin
      model_ctrl = data[2:0];
      model_clr = data[3];
    end
    while (!bvalid)
      tick();
    check_eq(32'({awready, wready}), 32'd0, "write ready with response pending");
    check_eq(32'(bresp), 32'd0, "write response");
    tick();
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [5:0] addr, output logic [31:0] data);
    arvalid = 1'b1;
    araddr = addr;
    while (!arready)
      tick();
    model_pop = (addr == `CT_REG_REC4);
    tick();
    model_pop = 1'b0;
    arvalid = 1'b0;
    rready = 1'b1;
    while (!rvalid)
      tick();
    data = rdata;
    check_eq(32'(arready), 32'd0, "read ready with data pending");
    check_eq(32'(rresp), 32'd0, "read response");
    tick();
    rready = 1'b0;
  endtask

  task automatic verify_status(input string what);
    logic [31:0] got;
    axi_read(`CT_REG_STATUS, got);
    check_eq(got, expected_status(), what);
  endtask

  // Trace for a while and then stop so the last record lands
  task automatic run_traced(input logic [2:0] ctrl, input int cycles);
    axi_write(`CT_REG_CTRL, 32'(ctrl));
    repeat (cycles) tick();
    axi_write(`CT_REG_CTRL, 32'd0);
    repeat (2) tick();
  endtask

  task automatic drain_records(input string tag, output int n);
    rec_t        exp;
    logic [31:0] got;
    n = 0;
    while (model_q.size() > 0) begin
      exp = model_q[0];
      for (int w = 0; w < `CT_REC_WORDS; w++) begin
        axi_read(6'(`CT_REG_REC0 + 4 * w), got);
        check_eq(got, exp[w], $sformatf("%s record %0d word %0d", tag, n, w));
      end
      n++;
    end
  endtask

  initial begin
    logic [31:0] got;
    int          n;
    void'($urandom(50258));
    reset_i = 1'b1;
    awvalid = 1'b0;
    awaddr = 6'd0;
    wvalid = 1'b0;
    wdata = 32'd0;
    wstrb = 4'h0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = 6'd0;
    rready = 1'b0;
    model_ctrl = 3'd0;
    model_clr = 1'b0;
    model_pop = 1'b0;
    pend_v = 1'b0;
    drive_core();
    repeat (10) tick();
    reset_i = 1'b0;
    tick();

    // Idle after reset with tracing off
    check_eq(32'({awready, wready, arready, bvalid, rvalid}), 32'b11100,
             "handshake after reset");
    axi_read(`CT_REG_STATUS, got);
    check_eq(got, 32'h0001_0000, "status after reset");
    axi_read(`CT_REG_CTRL, got);
    check_eq(got, 32'd0, "ctrl after reset");
    repeat (100) tick();
    axi_read(`CT_REG_STATUS, got);
    check_eq(got, 32'h0001_0000, "status with tracing off");
    axi_read(6'h3C, got);
    check_eq(got, 32'd0, "unmapped read");

    // Short unfiltered trace
    run_traced(3'b001, 8);
    check_eq(32'(model_q.size() > 0 && model_q.size() < DEPTH), 32'd1, "short trace size");
    verify_status("status after short trace");
    drain_records("plain", n);
    verify_status("status after plain drain");

    // Filters one at a time
    run_traced(3'b011, 10);
    verify_status("status with bubbles skipped");
    drain_records("skip bubbles", n);
    run_traced(3'b101, 10);
    verify_status("status with stalls skipped");
    drain_records("skip stalls", n);

    // Overflow keeps the oldest records
    run_traced(3'b001, 30);
    axi_read(`CT_REG_STATUS, got);
    check_eq(32'(got[17]), 32'd1, "full flag after overflow");
    check_eq(got, expected_status(), "status after overflow");
    axi_read(`CT_REG_DROP, got);
    check_eq(got, model_drop, "drop count");
    check_eq(32'(model_drop != 32'd0), 32'd1, "overflow produced drops");
    drain_records("overflow", n);
    check_eq(32'(n), 32'(DEPTH), "records kept on overflow");

    // Clear with skip bits set and a pop on empty
    run_traced(3'b001, 25);
    axi_write(`CT_REG_CTRL, 32'h0000_000E);
    repeat (2) tick();
    axi_read(`CT_REG_STATUS, got);
    check_eq(got, 32'h0001_0000, "status after clear");
    check_eq(got, expected_status(), "model status after clear");
    axi_read(`CT_REG_DROP, got);
    check_eq(got, 32'd0, "drop after clear");
    axi_read(`CT_REG_CTRL, got);
    check_eq(got, 32'h0000_0006, "ctrl readback after clear");
    axi_read(`CT_REG_REC4, got);
    axi_read(`CT_REG_STATUS, got);
    check_eq(got, 32'h0001_0000, "status after pop on empty");

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* core_trace_top.f */
+incdir+source
source/core_trace_pkg.sv
source/trace_stage_align.sv
source/trace_record_pack.sv
source/trace_fifo.sv
source/trace_csr.sv
source/core_trace_top.sv
dv/core_trace_chk.sv
dv/core_trace_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f core_trace_top.f \
  --top-module core_trace_tb -o core_trace_sim &&
./obj_dir/core_trace_sim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
